/* source/z80Defines_defines.svh */
// Opcode field positions, register codes and ALU operation codes, included by the package and RTL.
`ifndef Z80DEFINES_DEFINES_SVH
`define Z80DEFINES_DEFINES_SVH

`define Z80_QUAD_MSB 7
`define Z80_QUAD_LSB 6
`define Z80_DST_MSB 5
`define Z80_DST_LSB 3
`define Z80_SRC_MSB 2
`define Z80_SRC_LSB 0

`define Z80_REG_A 3'd7
`define Z80_REG_MEM 3'd6
`define Z80_IMM_LOW 3'b110

`define Z80_Q_LDN 2'b00
`define Z80_Q_LDR 2'b01
`define Z80_Q_ALUR 2'b10
`define Z80_Q_ALUN 2'b11

`define Z80_ALU_ADD 3'd0
`define Z80_ALU_ADC 3'd1
`define Z80_ALU_SUB 3'd2
`define Z80_ALU_SBC 3'd3
`define Z80_ALU_AND 3'd4
`define Z80_ALU_XOR 3'd5
`define Z80_ALU_OR 3'd6
`define Z80_ALU_CP 3'd7

`endif

/* source/z80ExecPkg.sv */
// Types shared by the execution core RTL and its testbench, referenced by scoped name.
`include "z80Defines_defines.svh"

package z80ExecPkg;

    typedef logic [7:0] byteT;
    typedef logic [2:0] regIdxT;   // codes follow the opcode order B C D E H L (HL) A.

    // same codes as bits 5:3 of an ALU opcode.
    typedef enum logic [2:0] {
        ADD = `Z80_ALU_ADD,
        ADC = `Z80_ALU_ADC,
        SUB = `Z80_ALU_SUB,
        SBC = `Z80_ALU_SBC,
        AND = `Z80_ALU_AND,
        XOR = `Z80_ALU_XOR,
        OR  = `Z80_ALU_OR,
        CP  = `Z80_ALU_CP
    } aluOpT;

    typedef struct packed {
        logic s;
        logic z;
        logic h;
        logic pv;
        logic n;
        logic c;
    } flagsT;

    typedef struct packed {
        byteT opcode;
        byteT immediate;   // zero for one-byte opcodes.
    } instrT;

    typedef struct packed {
        logic   regWrite;
        logic   flagWrite;
        logic   selImm;
        logic   selAlu;
        regIdxT dst;
        regIdxT src;
        aluOpT  aluOp;
    } ctrlWordT;

    typedef struct packed {
        logic   regWrite;
        regIdxT dst;
        byteT   value;
        logic   flagWrite;
        flagsT  flags;
    } commitT;

    typedef enum logic {
        OPCODE,
        IMMEDIATE
    } seqStateT;

endpackage

/* source/opcodeSequencer.sv */
// Gathers strobed opcode and immediate bytes into whole instructions for the decoder in execCore.
`timescale 1ns/1ps
`include "z80Defines_defines.svh"

module opcodeSequencer (
    input  logic              clk,
    input  logic              rstN,
    input  logic              byteValid,
    input  z80ExecPkg::byteT  byteData,
    output logic              instrValid,
    output z80ExecPkg::instrT instr
);

    z80ExecPkg::seqStateT state;
    z80ExecPkg::byteT     pendingOpcode;
    logic [1:0]           quad;
    logic                 needsImm;
    logic                 instrHasImm;

    assign quad = byteData[`Z80_QUAD_MSB:`Z80_QUAD_LSB];

    // only LD r,n and ALU A,n carry a second byte.
    assign needsImm = (quad == `Z80_Q_LDN || quad == `Z80_Q_ALUN)
                      && byteData[`Z80_SRC_MSB:`Z80_SRC_LSB] == `Z80_IMM_LOW;

    assign instrHasImm = (instr.opcode[`Z80_QUAD_MSB:`Z80_QUAD_LSB] == `Z80_Q_LDN
                          || instr.opcode[`Z80_QUAD_MSB:`Z80_QUAD_LSB] == `Z80_Q_ALUN)
                         && instr.opcode[`Z80_SRC_MSB:`Z80_SRC_LSB] == `Z80_IMM_LOW;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state      <= z80ExecPkg::OPCODE;
            instrValid <= 1'b0;
        end else begin
            instrValid <= 1'b0;
            if (byteValid) begin
                case (state)
                    z80ExecPkg::OPCODE: begin
                        if (needsImm) begin
                            state <= z80ExecPkg::IMMEDIATE;
                        end else begin
                            instrValid <= 1'b1;
                        end
                    end
                    z80ExecPkg::IMMEDIATE: begin
                        state      <= z80ExecPkg::OPCODE;   // any gap before this byte is fine.
                        instrValid <= 1'b1;
                    end
                    default: begin
                        state <= z80ExecPkg::OPCODE;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (byteValid) begin
            if (state == z80ExecPkg::OPCODE) begin
                pendingOpcode <= byteData;
                if (!needsImm) begin
                    instr.opcode    <= byteData;
                    instr.immediate <= '0;
                end
            end else begin
                instr.opcode    <= pendingOpcode;
                instr.immediate <= byteData;
            end
        end
    end

    // each instrValid delivers the byte strobed just before it, in the slot its form expects.
    assert property (@(posedge clk) disable iff (!rstN)
        instrValid |-> $past(byteValid)
                       && (instrHasImm ? instr.immediate == $past(byteData)
                                       : instr.opcode == $past(byteData)))
        else $error("instrValid does not carry the last strobed byte");

endmodule

/* source/instructionDecoder.sv */
// Quadrant decoder that turns a registered instruction into the control word of the core.
`timescale 1ns/1ps
`include "z80Defines_defines.svh"

module instructionDecoder (
    input  logic                 instrValid,
    input  z80ExecPkg::instrT    instr,
    output logic                 ctrlValid,
    output z80ExecPkg::ctrlWordT ctrl
);

    logic [1:0]         quad;
    logic [3:0]         quadSel;
    z80ExecPkg::regIdxT fieldY;
    z80ExecPkg::regIdxT fieldZ;
    logic               isCp;

    logic hit00;
    logic hit01;
    logic hit10;
    logic hit11;

    logic regWrite00;
    logic regWrite01;
    logic regWrite10;
    logic regWrite11;
    logic flagWrite10;
    logic flagWrite11;
    logic selImm00;
    logic selImm11;

    assign quad   = instr.opcode[`Z80_QUAD_MSB:`Z80_QUAD_LSB];
    assign fieldY = instr.opcode[`Z80_DST_MSB:`Z80_DST_LSB];
    assign fieldZ = instr.opcode[`Z80_SRC_MSB:`Z80_SRC_LSB];
    assign isCp   = fieldY == `Z80_ALU_CP;

    // a 2-to-4 select enables exactly one quadrant.
    always_comb begin
        quadSel       = '0;
        quadSel[quad] = 1'b1;
    end

    // quadrant 00 holds LD r,n. Other low patterns are outside this core.
    assign hit00      = quadSel[`Z80_Q_LDN] && fieldZ == `Z80_IMM_LOW
                        && fieldY != `Z80_REG_MEM;
    assign regWrite00 = hit00;
    assign selImm00   = hit00;

    // quadrant 01 is LD r,r'. (HL) on either side is dropped, which also drops HALT.
    assign hit01      = quadSel[`Z80_Q_LDR] && fieldY != `Z80_REG_MEM
                        && fieldZ != `Z80_REG_MEM;
    assign regWrite01 = hit01;

    // quadrant 10 is ALU A,r.
    assign hit10       = quadSel[`Z80_Q_ALUR] && fieldZ != `Z80_REG_MEM;
    assign regWrite10  = hit10 && !isCp;
    assign flagWrite10 = hit10;

    // quadrant 11 only supplies ALU A,n here.
    assign hit11       = quadSel[`Z80_Q_ALUN] && fieldZ == `Z80_IMM_LOW;
    assign regWrite11  = hit11 && !isCp;
    assign flagWrite11 = hit11;
    assign selImm11    = hit11;

    assign ctrlValid = instrValid && (hit00 || hit01 || hit10 || hit11);

    assign ctrl.regWrite  = regWrite00 | regWrite01 | regWrite10 | regWrite11;
    assign ctrl.flagWrite = flagWrite10 | flagWrite11;
    assign ctrl.selImm    = selImm00 | selImm11;
    assign ctrl.selAlu    = hit10 | hit11;
    assign ctrl.dst       = ({3{hit00 | hit01}} & fieldY)
                          | ({3{hit10 | hit11}} & `Z80_REG_A);   // ALU results land in A.
    assign ctrl.src       = {3{hit01 | hit10}} & fieldZ;
    assign ctrl.aluOp     = z80ExecPkg::aluOpT'({3{hit10 | hit11}} & fieldY);

endmodule

/* source/registerFile.sv */
// Eight-slot 8-bit register file of the core, two combinational reads and one clocked write.
`timescale 1ns/1ps
`include "z80Defines_defines.svh"

module registerFile (
    input  logic               clk,
    input  logic               rstN,
    input  logic               writeEn,
    input  z80ExecPkg::regIdxT writeIdx,
    input  z80ExecPkg::byteT   writeData,
    input  z80ExecPkg::regIdxT readIdxA,
    input  z80ExecPkg::regIdxT readIdxB,
    output z80ExecPkg::byteT   readA,
    output z80ExecPkg::byteT   readB,
    output z80ExecPkg::byteT   accum
);

    // slot 6 stands for (HL) and stays at zero.
    z80ExecPkg::byteT regs [0:7];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && writeIdx != `Z80_REG_MEM) begin
            regs[writeIdx] <= writeData;
        end
    end

    assign readA = regs[readIdxA];
    assign readB = regs[readIdxB];
    assign accum = regs[`Z80_REG_A];   // always the ALU's first operand.

    // the decoder must have filtered every (HL) destination.
    assert property (@(posedge clk) disable iff (!rstN)
        writeEn |-> writeIdx != `Z80_REG_MEM)
        else $error("register write aimed at (HL)");

endmodule

/* source/aluUnit.sv */
// 8-bit ALU with Z80 flag generation and the flag register, driven by the core's control word.
`timescale 1ns/1ps

module aluUnit (
    input  logic              clk,
    input  logic              rstN,
    input  z80ExecPkg::byteT  opA,
    input  z80ExecPkg::byteT  opB,
    input  z80ExecPkg::aluOpT aluOp,
    input  logic              flagWriteEn,
    output z80ExecPkg::byteT  result,
    output z80ExecPkg::flagsT newFlags,
    output z80ExecPkg::flagsT flags
);

    logic       isSub;
    logic       isLogic;
    logic       carryIn;
    logic [8:0] wide;
    logic [4:0] half;
    logic       overflow;

    assign isSub   = aluOp inside {z80ExecPkg::SUB, z80ExecPkg::SBC, z80ExecPkg::CP};
    assign isLogic = aluOp inside {z80ExecPkg::AND, z80ExecPkg::XOR, z80ExecPkg::OR};
    assign carryIn = (aluOp == z80ExecPkg::ADC || aluOp == z80ExecPkg::SBC) && flags.c;

    // bit 8 of wide is carry or borrow, bit 4 of half is the nibble carry or borrow.
    always_comb begin
        if (isSub) begin
            wide = {1'b0, opA} - {1'b0, opB} - {8'd0, carryIn};
            half = {1'b0, opA[3:0]} - {1'b0, opB[3:0]} - {4'd0, carryIn};
        end else begin
            wide = {1'b0, opA} + {1'b0, opB} + {8'd0, carryIn};
            half = {1'b0, opA[3:0]} + {1'b0, opB[3:0]} + {4'd0, carryIn};
        end
    end

    // signed overflow shows as a sign change that the operands cannot explain.
    assign overflow = isSub ? (opA[7] != opB[7]) && (wide[7] != opA[7])
                            : (opA[7] == opB[7]) && (wide[7] != opA[7]);

    always_comb begin
        case (aluOp)
            z80ExecPkg::AND: result = opA & opB;
            z80ExecPkg::XOR: result = opA ^ opB;
            z80ExecPkg::OR:  result = opA | opB;
            default:         result = wide[7:0];   // CP keeps the difference for its flags.
        endcase
    end

    always_comb begin
        newFlags.s  = result[7];
        newFlags.z  = result == 8'h00;
        newFlags.h  = isLogic ? (aluOp == z80ExecPkg::AND) : half[4];
        newFlags.pv = isLogic ? ~^result : overflow;   // even parity for logic ops.
        newFlags.n  = isSub;
        newFlags.c  = isLogic ? 1'b0 : wide[8];
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            flags <= '0;
        end else if (flagWriteEn) begin
            flags <= newFlags;
        end
    end

endmodule

/* source/execCore.sv */
// Top level of the execution core. Takes a byte strobe stream and emits one commit per instruction.
`timescale 1ns/1ps

module execCore (
    input  logic               clk,
    input  logic               rstN,
    input  logic               byteValid,
    input  z80ExecPkg::byteT   byteData,
    output logic               commitValid,
    output z80ExecPkg::commitT commit
);

    logic                 instrValid;
    z80ExecPkg::instrT    instr;
    logic                 ctrlValid;
    z80ExecPkg::ctrlWordT ctrl;
    z80ExecPkg::byteT     dstData;
    z80ExecPkg::byteT     srcData;
    z80ExecPkg::byteT     accum;
    z80ExecPkg::byteT     operandB;
    z80ExecPkg::byteT     aluResult;
    z80ExecPkg::byteT     writeValue;
    z80ExecPkg::flagsT    aluFlags;
    z80ExecPkg::flagsT    storedFlags;
    z80ExecPkg::commitT   nextCommit;
    logic                 regWriteEn;
    logic                 flagWriteEn;

    opcodeSequencer u_sequencer (
        .clk        (clk),
        .rstN       (rstN),
        .byteValid  (byteValid),
        .byteData   (byteData),
        .instrValid (instrValid),
        .instr      (instr)
    );

    instructionDecoder u_decoder (
        .instrValid (instrValid),
        .instr      (instr),
        .ctrlValid  (ctrlValid),
        .ctrl       (ctrl)
    );

    assign operandB    = ctrl.selImm ? instr.immediate : srcData;
    assign writeValue  = ctrl.selAlu ? aluResult : operandB;
    assign regWriteEn  = ctrlValid && ctrl.regWrite;
    assign flagWriteEn = ctrlValid && ctrl.flagWrite;

    // writes land at the end of the decode cycle, so the next instruction sees them.
    registerFile u_regFile (
        .clk       (clk),
        .rstN      (rstN),
        .writeEn   (regWriteEn),
        .writeIdx  (ctrl.dst),
        .writeData (writeValue),
        .readIdxA  (ctrl.dst),
        .readIdxB  (ctrl.src),
        .readA     (dstData),
        .readB     (srcData),
        .accum     (accum)
    );

    aluUnit u_alu (
        .clk         (clk),
        .rstN        (rstN),
        .opA         (accum),
        .opB         (operandB),
        .aluOp       (ctrl.aluOp),
        .flagWriteEn (flagWriteEn),
        .result      (aluResult),
        .newFlags    (aluFlags),
        .flags       (storedFlags)
    );

    // a load reports the flags it left untouched. CP reports its difference as value.
    always_comb begin
        nextCommit.regWrite  = ctrl.regWrite;
        nextCommit.dst       = ctrl.dst;
        nextCommit.value     = writeValue;
        nextCommit.flagWrite = ctrl.flagWrite;
        nextCommit.flags     = ctrl.flagWrite ? aluFlags : storedFlags;
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            commitValid <= 1'b0;
        end else begin
            commitValid <= ctrlValid;
        end
    end

    always_ff @(posedge clk) begin
        if (ctrlValid) begin
            commit <= nextCommit;
        end
    end

    // a committed register write must read back from the file while its record is shown.
    assert property (@(posedge clk) disable iff (!rstN)
        commitValid && commit.regWrite && ctrl.dst == commit.dst |-> dstData == commit.value)
        else $error("register file does not hold the committed value");

endmodule

/* test/clockGen.sv */
// Free-running 4 ns clock source for the execution core testbench.
`timescale 1ns/1ps

module clockGen (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #2 clk = ~clk;   // half of the 4 ns period.

endmodule

/* test/execCoreTb.sv */
// Testbench for execCore that drives byte strobes, predicts each commit and checks it with assertions.
`timescale 1ns/1ps
`include "z80Defines_defines.svh"

module execCoreTb;

    localparam int cycleLimit = 4000;   // the stimulus needs about 700 cycles, so this leaves a wide margin.

    logic               clk;
    logic               rstN;
    logic               byteValid;
    z80ExecPkg::byteT   byteData;
    logic               commitValid;
    z80ExecPkg::commitT commit;

    z80ExecPkg::commitT expQ[$];
    int                 dueQ[$];
    z80ExecPkg::byteT   modelRegs [0:7];
    z80ExecPkg::flagsT  modelFlags;
    logic               headValid;
    z80ExecPkg::commitT headCommit;
    int                 headDue;
    int                 cycleCount;

    clockGen u_clk (.clk(clk));

    execCore u_dut (
        .clk         (clk),
        .rstN        (rstN),
        .byteValid   (byteValid),
        .byteData    (byteData),
        .commitValid (commitValid),
        .commit      (commit)
    );

    task automatic stopWithFailure(input string why);
        $display("Result: FAILED");
        $fatal(1, "%s", why);
    endtask

    task automatic reportCommitMismatch(input z80ExecPkg::commitT got,
                                        input z80ExecPkg::commitT want);
        if (got.regWrite != want.regWrite)
            $display("MISMATCH commit.regWrite expected 0x%h got 0x%h",
                     want.regWrite, got.regWrite);
        if (got.dst != want.dst)
            $display("MISMATCH commit.dst expected 0x%h got 0x%h", want.dst, got.dst);
        if (got.value != want.value)
            $display("MISMATCH commit.value expected 0x%02h got 0x%02h", want.value, got.value);
        if (got.flagWrite != want.flagWrite)
            $display("MISMATCH commit.flagWrite expected 0x%h got 0x%h",
                     want.flagWrite, got.flagWrite);
        if (got.flags != want.flags)
            $display("MISMATCH commit.flags expected 0x%02h got 0x%02h", want.flags, got.flags);
        stopWithFailure("commit record differs from the reference model");
    endtask

    function automatic logic hasImmediate(input z80ExecPkg::byteT op);
        return (op[7:6] == `Z80_Q_LDN || op[7:6] == `Z80_Q_ALUN) && op[2:0] == `Z80_IMM_LOW;
    endfunction

    function automatic z80ExecPkg::regIdxT randomReg();
        z80ExecPkg::regIdxT r;
        r = 3'($urandom_range(0, 6));
        if (r == `Z80_REG_MEM) r = `Z80_REG_A;   // (HL) is not a real register here.
        return r;
    endfunction

    // computes on whole integers and reads each flag off the value range.
    function automatic void aluReference(input z80ExecPkg::aluOpT op, input z80ExecPkg::byteT a,
            input z80ExecPkg::byteT b, input logic cin,
            output z80ExecPkg::byteT r, output z80ExecPkg::flagsT f);
        int full;
        int nib;
        int sgn;
        int c;
        c = (op == z80ExecPkg::ADC || op == z80ExecPkg::SBC) ? int'(cin) : 0;
        f = '0;
        case (op)
            z80ExecPkg::ADD, z80ExecPkg::ADC: begin
                full = int'(a) + int'(b) + c;
                nib  = int'(a[3:0]) + int'(b[3:0]) + c;
                sgn  = int'($signed(a)) + int'($signed(b)) + c;
                r    = full[7:0];
                f.c  = full > 255;
                f.h  = nib > 15;
                f.pv = sgn > 127 || sgn < -128;
            end
            z80ExecPkg::SUB, z80ExecPkg::SBC, z80ExecPkg::CP: begin
                full = int'(a) - int'(b) - c;
                nib  = int'(a[3:0]) - int'(b[3:0]) - c;
                sgn  = int'($signed(a)) - int'($signed(b)) - c;
                r    = full[7:0];
                f.c  = full < 0;
                f.h  = nib < 0;
                f.pv = sgn > 127 || sgn < -128;
                f.n  = 1'b1;
            end
            default: begin
                if (op == z80ExecPkg::AND) r = a & b;
                else if (op == z80ExecPkg::XOR) r = a ^ b;
                else r = a | b;
                f.h  = op == z80ExecPkg::AND;
                f.pv = ($countones(r) % 2) == 0;
            end
        endcase
        f.s = r[7];
        f.z = r == 8'h00;
    endfunction

    // called while the final byte is on the bus, so the commit is due two cycles later.
    task automatic predictCommit(input z80ExecPkg::byteT opcode, input z80ExecPkg::byteT imm);
        z80ExecPkg::regIdxT y;
        z80ExecPkg::regIdxT z;
        z80ExecPkg::byteT   operand;
        z80ExecPkg::byteT   res;
        z80ExecPkg::flagsT  f;
        z80ExecPkg::commitT c;
        logic               found;
        y     = opcode[5:3];
        z     = opcode[2:0];
        found = 1'b0;
        c     = '0;
        if (opcode[7:6] == `Z80_Q_LDN && z == `Z80_IMM_LOW && y != `Z80_REG_MEM) begin
            found   = 1'b1;
            c.value = imm;
        end else if (opcode[7:6] == `Z80_Q_LDR && y != `Z80_REG_MEM && z != `Z80_REG_MEM) begin
            found   = 1'b1;
            c.value = modelRegs[z];
        end
        if (found) begin
            c.regWrite   = 1'b1;
            c.dst        = y;
            c.flags      = modelFlags;   // loads leave the flags alone.
            modelRegs[y] = c.value;
        end
        if ((opcode[7:6] == `Z80_Q_ALUR && z != `Z80_REG_MEM)
                || (opcode[7:6] == `Z80_Q_ALUN && z == `Z80_IMM_LOW)) begin
            found   = 1'b1;
            operand = (opcode[7:6] == `Z80_Q_ALUN) ? imm : modelRegs[z];
            aluReference(z80ExecPkg::aluOpT'(y), modelRegs[`Z80_REG_A], operand,
                         modelFlags.c, res, f);
            c.regWrite  = y != `Z80_ALU_CP;
            c.dst       = `Z80_REG_A;
            c.value     = res;
            c.flagWrite = 1'b1;
            c.flags     = f;
            modelFlags  = f;
            if (c.regWrite) modelRegs[`Z80_REG_A] = res;
        end
        if (found) begin
            expQ.push_back(c);
            dueQ.push_back(cycleCount + 2);
        end
    endtask

    task automatic idleCycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic driveByte(input z80ExecPkg::byteT b);
        byteValid = 1'b1;
        byteData  = b;
        @(posedge clk);
        #1;
        byteValid = 1'b0;
    endtask

    task automatic issueInstr(input z80ExecPkg::byteT opcode, input z80ExecPkg::byteT imm,
                              input int gap);
        if (hasImmediate(opcode)) begin
            driveByte(opcode);
            idleCycles(gap);
            predictCommit(opcode, imm);
            driveByte(imm);
        end else begin
            predictCommit(opcode, imm);
            driveByte(opcode);
        end
    endtask

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) stopWithFailure("timeout, the run exceeded its cycle limit");
    end

    always @(posedge clk) begin
        if (rstN && commitValid && expQ.size() != 0) begin
            void'(expQ.pop_front());
            void'(dueQ.pop_front());
        end
    end

    always @(negedge clk) begin
        headValid = expQ.size() != 0;   // stable for the next rising edge.
        if (headValid) begin
            headCommit = expQ[0];
            headDue    = dueQ[0];
        end
    end

    assert property (@(posedge clk) disable iff (!rstN) commitValid |-> headValid)
        else stopWithFailure("a commit arrived while no instruction was expected");

    assert property (@(posedge clk) disable iff (!rstN)
        commitValid && headValid |-> commit == headCommit)
        else reportCommitMismatch($sampled(commit), $sampled(headCommit));

    assert property (@(posedge clk) disable iff (!rstN) headValid |-> cycleCount <= headDue)
        else stopWithFailure("an instruction did not commit two cycles after its final byte");

    initial begin
        z80ExecPkg::byteT op;
        int               waited;
        rstN       = 1'b0;
        byteValid  = 1'b0;
        byteData   = '0;
        headValid  = 1'b0;
        headCommit = '0;
        headDue    = 0;
        modelFlags = '0;
        for (int r = 0; r < 8; r++) modelRegs[r] = '0;
        void'($urandom(67));
        repeat (10) @(posedge clk);
        #1;
        rstN = 1'b1;
        for (int r = 0; r < 8; r++) begin
            if (r != `Z80_REG_MEM) begin
                issueInstr({2'b00, 3'(r), 3'b110}, 8'($urandom), $urandom_range(0, 3));
            end
        end
        repeat (20) issueInstr({2'b01, randomReg(), randomReg()}, 8'h00, 0);
        issueInstr(8'h3E, 8'hFF, 0);
        issueInstr(8'hC6, 8'h01, 0);   // carry out of bit 7.
        issueInstr(8'hCE, 8'h7F, 1);
        issueInstr(8'hD6, 8'h81, 0);
        issueInstr(8'hDE, 8'h00, 0);   // borrow feeds SBC.
        issueInstr(8'h8F, 8'h00, 0);
        issueInstr(8'h9F, 8'h00, 0);
        repeat (120) begin
            if ($urandom_range(0, 1) == 1) op = {2'b11, 3'($urandom_range(0, 7)), 3'b110};
            else op = {2'b10, 3'($urandom_range(0, 7)), randomReg()};
            issueInstr(op, 8'($urandom), $urandom_range(0, 2));
            if ($urandom_range(0, 3) == 0) begin
                issueInstr({2'b00, randomReg(), 3'b110}, 8'($urandom), 0);
            end
            idleCycles($urandom_range(0, 1));
        end
        issueInstr(8'h00, 8'h00, 0);
        issueInstr(8'h76, 8'h00, 0);
        issueInstr(8'h36, 8'h5A, 2);   // LD (HL),n still takes two bytes.
        issueInstr(8'h7E, 8'h00, 0);
        issueInstr(8'h86, 8'h00, 0);
        issueInstr(8'hCB, 8'h00, 0);
        repeat (80) issueInstr(8'($urandom), 8'($urandom), $urandom_range(0, 1));
        repeat (40) begin
            if ($urandom_range(0, 1) == 1) op = {2'b10, 3'($urandom_range(0, 7)), 3'd7};
            else op = {2'b11, 3'($urandom_range(0, 7)), 3'b110};
            issueInstr(op, 8'($urandom), 0);
        end
        waited = 0;
        while (expQ.size() != 0 && waited < 10) begin
            @(posedge clk);
            waited++;
        end
        idleCycles(4);
        if (expQ.size() == 0) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            stopWithFailure("instructions were still waiting for a commit at the end");
        end
    end

endmodule

/* z80Exec.f */
+incdir+source
source/z80ExecPkg.sv
source/opcodeSequencer.sv
source/instructionDecoder.sv
source/registerFile.sv
source/aluUnit.sv
source/execCore.sv
test/clockGen.sv
test/execCoreTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= execCoreTb
FILELIST  ?= z80Exec.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST)) source/z80Defines_defines.svh
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'Result: PASSED'

clean:
	rm -rf $(OBJ_DIR)
